// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
		-f filelist.f --Mdir obj_dir -o Vtb_cpu
	./obj_dir/Vtb_cpu

clean:
	rm -rf obj_dir

// ==== dv/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();
	localparam word_t START_PC = 32'h0000_0000;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int MAX_STORES = 64;
	localparam int MAX_STEPS = 1000;
	localparam int DRAIN_CYCLES = 20;

	logic  clock;
	logic  reset;
	logic  do_system;
	logic  dm_ready;
	logic  dm_enable;
	logic  dm_write;
	word_t im_address;
	word_t im_data;
	word_t dm_address;
	word_t dm_wdata;
	word_t dm_rdata;

	word_t  imem [0:IMEM_WORDS-1];
	word_t  dmem [0:DMEM_WORDS-1];
	word_t  exp_addr [0:MAX_STORES-1];
	word_t  exp_data [0:MAX_STORES-1];
	int     store_total;
	int     store_count;
	int     model_instr_count;
	int     cycle_count;
	int     cycle_limit;
	int     pos;
	bit     running;
	integer seed;

	cpu #(
		.RESET_PC(START_PC)
	) dut (
		.clock(clock),
		.reset(reset),
		.do_system(do_system),
		.im_address(im_address),
		.im_data(im_data),
		.dm_enable(dm_enable),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata),
		.dm_ready(dm_ready)
	);

	assign im_data = imem[im_address[9:2]];
	assign dm_rdata = dmem[dm_address[9:2]];

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic word_t fill_word(int idx);
		return (word_t'(idx) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
	endfunction

	function automatic word_t r_form(logic [4:0] sub_op, int rt, int ra, int rb);
		instr_t ins;
		ins = '0;
		ins.r.opcode = OP_ALU;
		ins.r.rt = rt[4:0];
		ins.r.ra = ra[4:0];
		ins.r.rb = rb[4:0];
		ins.r.sub_op = sub_op;
		return ins;
	endfunction

	function automatic word_t i_form(opcode_t op, int rt, int ra, int imm);
		instr_t ins;
		ins = '0;
		ins.i.opcode = op;
		ins.i.rt = rt[4:0];
		ins.i.ra = ra[4:0];
		ins.i.imm15 = imm[14:0];
		return ins;
	endfunction

	task automatic place_instr(word_t word);
		imem[pos] = word;
		pos = pos + 1;
	endtask

	task automatic load_program();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = '0;
		end
		pos = 0;
		// dependent alu chain
		place_instr(i_form(OP_ADDI, 1, 0, 5));
		place_instr(i_form(OP_ADDI, 2, 1, -3));
		place_instr(r_form(SUB_ADD, 3, 1, 2));
		place_instr(r_form(SUB_SUB, 4, 2, 3));
		place_instr(r_form(SUB_XOR, 5, 3, 4));
		place_instr(r_form(SUB_AND, 6, 5, 3));
		place_instr(r_form(SUB_OR, 7, 6, 1));
		place_instr(r_form(SUB_SLT, 8, 4, 1));
		place_instr(r_form(SUB_SLT, 9, 1, 4));
		place_instr(i_form(OP_ORI, 10, 3, 'h4a5a));
		place_instr(i_form(OP_ADDI, 11, 0, -16384));
		for (int r = 3; r <= 11; r++) begin
			place_instr(i_form(OP_SWI, r, 0, 64 + 4 * r));
		end
		// execute result wins over the older one in memory
		place_instr(i_form(OP_ADDI, 12, 11, 1));
		place_instr(i_form(OP_ADDI, 12, 12, 2));
		place_instr(i_form(OP_SWI, 12, 0, 124));
		// load-use, load two ahead of its store, load straight into a store
		place_instr(i_form(OP_LWI, 14, 0, 8));
		place_instr(i_form(OP_ADDI, 15, 14, 1));
		place_instr(i_form(OP_SWI, 15, 0, 128));
		place_instr(i_form(OP_LWI, 16, 0, 12));
		place_instr(i_form(OP_ADDI, 17, 0, 3));
		place_instr(i_form(OP_SWI, 16, 0, 132));
		place_instr(i_form(OP_LWI, 18, 0, 76));
		place_instr(i_form(OP_SWI, 18, 0, 136));
		// taken branches skip stores
		place_instr(i_form(OP_BEQ, 1, 1, 3));
		place_instr(i_form(OP_SWI, 1, 0, 200));
		place_instr(i_form(OP_SWI, 2, 0, 204));
		place_instr(i_form(OP_BNE, 1, 2, 3));
		place_instr(i_form(OP_SWI, 1, 0, 208));
		place_instr(i_form(OP_SWI, 2, 0, 212));
		// not taken
		place_instr(i_form(OP_BEQ, 1, 2, 2));
		place_instr(i_form(OP_SWI, 1, 0, 140));
		place_instr(i_form(OP_BNE, 2, 2, 2));
		place_instr(i_form(OP_SWI, 2, 0, 144));
		// branch on a fresh load
		place_instr(i_form(OP_LWI, 20, 0, 76));
		place_instr(i_form(OP_BEQ, 20, 3, 2));
		place_instr(i_form(OP_SWI, 1, 0, 216));
		// counted loop
		place_instr(i_form(OP_ADDI, 21, 0, 3));
		place_instr(i_form(OP_ADDI, 22, 0, 160));
		place_instr(r_form(SUB_ADD, 23, 23, 21));
		place_instr(i_form(OP_SWI, 23, 22, 0));
		place_instr(i_form(OP_ADDI, 22, 22, 4));
		place_instr(i_form(OP_ADDI, 21, 21, -1));
		place_instr(i_form(OP_BNE, 21, 0, -4));
		// halt, the store behind it is always squashed
		place_instr(i_form(OP_BEQ, 0, 0, 0));
		place_instr(i_form(OP_SWI, 1, 0, 220));
	endtask

	// instruction-level model, fills the expected store list
	function automatic int run_model();
		word_t  regs [0:31];
		word_t  mem [0:DMEM_WORDS-1];
		instr_t ins;
		word_t  pc_now;
		word_t  next_pc;
		word_t  a;
		word_t  b;
		word_t  rt_val;
		word_t  sext;
		word_t  addr;
		word_t  wr_val;
		bit     wr_en;
		bit     halted;
		int     stores;
		int     steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			mem[i] = fill_word(i);
		end
		pc_now = START_PC;
		halted = 1'b0;
		stores = 0;
		steps = 0;
		while (!halted && steps < MAX_STEPS) begin
			ins = imem[pc_now[9:2]];
			a = regs[ins.r.ra];
			b = regs[ins.r.rb];
			rt_val = regs[ins.r.rt];
			sext = {{17{ins.i.imm15[14]}}, ins.i.imm15};
			addr = a + sext;
			next_pc = pc_now + 32'd4;
			wr_en = 1'b0;
			wr_val = '0;
			case (ins.r.opcode)
				OP_ALU: begin
					wr_en = 1'b1;
					case (ins.r.sub_op)
						SUB_ADD: wr_val = a + b;
						SUB_SUB: wr_val = a - b;
						SUB_AND: wr_val = a & b;
						SUB_OR:  wr_val = a | b;
						SUB_XOR: wr_val = a ^ b;
						SUB_SLT: wr_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr_en = 1'b0;
					endcase
				end
				OP_ADDI: begin
					wr_en = 1'b1;
					wr_val = a + sext;
				end
				OP_ORI: begin
					wr_en = 1'b1;
					wr_val = a | {17'b0, ins.i.imm15};
				end
				OP_LWI: begin
					wr_en = 1'b1;
					wr_val = mem[addr[9:2]];
				end
				OP_SWI: begin
					mem[addr[9:2]] = rt_val;
					if (stores < MAX_STORES) begin
						exp_addr[stores] = addr;
						exp_data[stores] = rt_val;
						stores = stores + 1;
					end
				end
				OP_BEQ: begin
					if (rt_val == a) begin
						next_pc = pc_now + {sext[29:0], 2'b00};
					end
				end
				OP_BNE: begin
					if (rt_val != a) begin
						next_pc = pc_now + {sext[29:0], 2'b00};
					end
				end
				default: begin
				end
			endcase
			if (wr_en && ins.r.rt != '0) begin
				regs[ins.r.rt] = wr_val;
			end
			halted = (next_pc == pc_now);
			pc_now = next_pc;
			steps = steps + 1;
		end
		model_instr_count = steps;
		return stores;
	endfunction

	task automatic check_value(input string what, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("** Error: %s expected %h actual %h", what, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// stores complete on an edge with the port enabled and the core running
	always @(posedge clock) begin
		if (!reset && dm_enable && dm_write && dm_ready && do_system) begin
			if (store_count >= store_total) begin
				$display("store to %h seen after the expected sequence ended", dm_address);
				$display("CHECKS FAILED");
				$fatal(1, "unexpected store");
			end else begin
				check_value($sformatf("store %0d address", store_count),
					exp_addr[store_count], dm_address);
				check_value($sformatf("store %0d data", store_count),
					exp_data[store_count], dm_wdata);
				dmem[dm_address[9:2]] <= dm_wdata;
				store_count <= store_count + 1;
			end
		end
	end

	always @(posedge clock) begin
		if (running) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= cycle_limit) begin
				$display("timeout, no completion within %0d cycles", cycle_limit);
				$display("CHECKS FAILED");
				$fatal(1, "timeout");
			end
		end
	end

	// random freezes from either side
	initial begin
		wait (running);
		forever begin
			@(negedge clock);
			do_system = (($random(seed) & 3) != 0);
			dm_ready = (($random(seed) & 3) != 0);
		end
	end

	initial begin
		seed = 32'h77e2009e;
		reset = 1'b1;
		do_system = 1'b0;
		dm_ready = 1'b0;
		running = 1'b0;
		store_count = 0;
		cycle_count = 0;
		load_program();
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = fill_word(i);
		end
		store_total = run_model();
		cycle_limit = 10 * model_instr_count + 100;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		repeat (2) @(negedge clock);
		check_value("fetch address after reset", START_PC, im_address);
		check_value("dm_enable after reset", 32'd0, word_t'(dm_enable));
		dm_ready = 1'b1;
		@(negedge clock);
		check_value("fetch address held without do_system", START_PC, im_address);
		running = 1'b1;
		wait (store_count == store_total);
		// extra stores in this window are caught by the compare process
		repeat (DRAIN_CYCLES) @(negedge clock);
		$display("ALL CHECKS PASSED");
		$finish;
	end
endmodule

// ==== filelist.f ====
verilog/cpu_pkg.sv
verilog/pc.sv
verilog/regwalls.sv
verilog/controller.sv
verilog/regfile.sv
verilog/forward.sv
verilog/alu.sv
verilog/cpu.sv
dv/tb_cpu.sv

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  alu_op_t alu_op,
	input  word_t   src_a,
	input  word_t   src_b,
	input  word_t   cmp_a,
	input  word_t   cmp_b,
	input  word_t   imm_value,
	input  word_t   ex_pc,
	input  logic    is_branch,
	input  logic    branch_on_equal,
	output word_t   result,
	output logic    branch_taken,
	output word_t   branch_target
);
	logic operands_equal;

	always_comb begin
		case (alu_op)
			ALU_ADD: result = src_a + src_b;
			ALU_SUB: result = src_a - src_b;
			ALU_AND: result = src_a & src_b;
			ALU_OR:  result = src_a | src_b;
			ALU_XOR: result = src_a ^ src_b;
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
			default: result = '0;
		endcase
	end

	// rt against ra, offset counts words from the branch itself
	assign operands_equal = (cmp_a == cmp_b);
	assign branch_taken = is_branch && (branch_on_equal ? operands_equal : !operands_equal);
	assign branch_target = ex_pc + {imm_value[XLEN-3:0], 2'b00};
endmodule

// ==== verilog/controller.sv ====
`timescale 1ns/1ps

module controller import cpu_pkg::*; (
	input  instr_t    instruction,
	output alu_op_t   alu_op,
	output logic      use_imm,
	output word_t     imm_value,
	output logic      reg_write,
	output reg_addr_t dest_reg,
	output logic      mem_read,
	output logic      mem_write,
	output logic      is_branch,
	output logic      branch_on_equal,
	output wb_sel_t   wb_sel
);
	word_t sign_imm;
	word_t zero_imm;

	assign sign_imm = {{(XLEN-15){instruction.i.imm15[14]}}, instruction.i.imm15};
	assign zero_imm = {{(XLEN-15){1'b0}}, instruction.i.imm15};
	assign dest_reg = instruction.r.rt;

	always_comb begin
		// defaults form a no-op
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		imm_value = sign_imm;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		branch_on_equal = 1'b0;
		wb_sel = WB_ALU;
		case (instruction.r.opcode)
			OP_ALU: begin
				reg_write = 1'b1;
				case (instruction.r.sub_op)
					SUB_ADD: alu_op = ALU_ADD;
					SUB_SUB: alu_op = ALU_SUB;
					SUB_AND: alu_op = ALU_AND;
					SUB_OR:  alu_op = ALU_OR;
					SUB_XOR: alu_op = ALU_XOR;
					SUB_SLT: alu_op = ALU_SLT;
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			OP_ORI: begin
				alu_op = ALU_OR;
				use_imm = 1'b1;
				imm_value = zero_imm;
				reg_write = 1'b1;
			end
			OP_LWI: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
				wb_sel = WB_MEM;
			end
			OP_SWI: begin
				use_imm = 1'b1;
				mem_write = 1'b1;
			end
			OP_BEQ: begin
				alu_op = ALU_SUB;
				is_branch = 1'b1;
				branch_on_equal = 1'b1;
			end
			OP_BNE: begin
				alu_op = ALU_SUB;
				is_branch = 1'b1;
			end
			default: begin
			end
		endcase
	end
endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps

module cpu import cpu_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  do_system,
	output word_t im_address,
	input  word_t im_data,
	output logic  dm_enable,
	output logic  dm_write,
	output word_t dm_address,
	output word_t dm_wdata,
	input  word_t dm_rdata,
	input  logic  dm_ready
);
	logic enable_system;

	// decode
	instr_t    id_instruction;
	word_t     id_pc;
	alu_op_t   id_alu_op;
	logic      id_use_imm;
	word_t     id_imm_value;
	logic      id_reg_write;
	reg_addr_t id_dest_reg;
	logic      id_mem_read;
	logic      id_mem_write;
	logic      id_is_branch;
	logic      id_branch_on_equal;
	wb_sel_t   id_wb_sel;
	logic      use_ra;
	logic      use_rb;
	logic      use_rt;
	word_t     reg_ra_data;
	word_t     reg_rb_data;
	word_t     reg_rt_data;
	word_t     fwd_ra;
	word_t     fwd_rb;
	word_t     fwd_rt;
	logic      load_stall;

	// execute
	alu_op_t   ex_alu_op;
	word_t     ex_src_a;
	word_t     ex_src_b;
	word_t     ex_rt_data;
	word_t     ex_imm_value;
	word_t     ex_pc;
	logic      ex_is_branch;
	logic      ex_branch_on_equal;
	logic      ex_reg_write;
	reg_addr_t ex_dest_reg;
	logic      ex_mem_read;
	word_t     ex_result;
	logic      branch_taken;
	word_t     branch_target;

	// memory and writeback
	logic      mem_reg_write;
	reg_addr_t mem_dest_reg;
	word_t     mem_value;
	logic      wb_write_enable;
	reg_addr_t wb_write_addr;
	word_t     wb_write_data;

	// nothing moves unless the system runs and data memory is ready
	assign enable_system = do_system && dm_ready;

	// every valid instruction reads ra as its first operand or base
	assign use_ra = id_reg_write || id_mem_write || id_is_branch;
	assign use_rb = id_reg_write && !id_use_imm;
	assign use_rt = id_mem_write || id_is_branch;

	pc #(
		.RESET_PC(RESET_PC)
	) u_pc (
		.clock(clock),
		.reset(reset),
		.enable(enable_system),
		.load_stall(load_stall),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.current_pc(im_address)
	);

	regwalls u_regwalls (
		.clock(clock),
		.reset(reset),
		.enable(enable_system),
		.load_stall(load_stall),
		.branch_taken(branch_taken),
		.fetch_pc(im_address),
		.im_data(im_data),
		.id_alu_op(id_alu_op),
		.id_use_imm(id_use_imm),
		.id_imm_value(id_imm_value),
		.id_reg_write(id_reg_write),
		.id_dest_reg(id_dest_reg),
		.id_mem_read(id_mem_read),
		.id_mem_write(id_mem_write),
		.id_is_branch(id_is_branch),
		.id_branch_on_equal(id_branch_on_equal),
		.id_wb_sel(id_wb_sel),
		.fwd_ra(fwd_ra),
		.fwd_rb(fwd_rb),
		.fwd_rt(fwd_rt),
		.ex_result(ex_result),
		.dm_rdata(dm_rdata),
		.id_instruction(id_instruction),
		.id_pc(id_pc),
		.ex_alu_op(ex_alu_op),
		.ex_src_a(ex_src_a),
		.ex_src_b(ex_src_b),
		.ex_rt_data(ex_rt_data),
		.ex_imm_value(ex_imm_value),
		.ex_pc(ex_pc),
		.ex_is_branch(ex_is_branch),
		.ex_branch_on_equal(ex_branch_on_equal),
		.ex_reg_write(ex_reg_write),
		.ex_dest_reg(ex_dest_reg),
		.ex_mem_read(ex_mem_read),
		.mem_reg_write(mem_reg_write),
		.mem_dest_reg(mem_dest_reg),
		.mem_value(mem_value),
		.dm_enable(dm_enable),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_wdata(dm_wdata),
		.write_enable(wb_write_enable),
		.write_addr(wb_write_addr),
		.write_data(wb_write_data)
	);

	controller u_controller (
		.instruction(id_instruction),
		.alu_op(id_alu_op),
		.use_imm(id_use_imm),
		.imm_value(id_imm_value),
		.reg_write(id_reg_write),
		.dest_reg(id_dest_reg),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.is_branch(id_is_branch),
		.branch_on_equal(id_branch_on_equal),
		.wb_sel(id_wb_sel)
	);

	regfile u_regfile (
		.clock(clock),
		.reset(reset),
		.enable(enable_system),
		.ra_addr(id_instruction.r.ra),
		.rb_addr(id_instruction.r.rb),
		.rt_addr(id_instruction.r.rt),
		.ra_data(reg_ra_data),
		.rb_data(reg_rb_data),
		.rt_data(reg_rt_data),
		.write_enable(wb_write_enable),
		.write_addr(wb_write_addr),
		.write_data(wb_write_data)
	);

	forward u_forward (
		.ra_addr(id_instruction.r.ra),
		.rb_addr(id_instruction.r.rb),
		.rt_addr(id_instruction.r.rt),
		.ra_data(reg_ra_data),
		.rb_data(reg_rb_data),
		.rt_data(reg_rt_data),
		.use_ra(use_ra),
		.use_rb(use_rb),
		.use_rt(use_rt),
		.ex_dest_reg(ex_dest_reg),
		.ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read),
		.ex_result(ex_result),
		.mem_dest_reg(mem_dest_reg),
		.mem_reg_write(mem_reg_write),
		.mem_value(mem_value),
		.fwd_ra(fwd_ra),
		.fwd_rb(fwd_rb),
		.fwd_rt(fwd_rt),
		.load_stall(load_stall)
	);

	alu u_alu (
		.alu_op(ex_alu_op),
		.src_a(ex_src_a),
		.src_b(ex_src_b),
		.cmp_a(ex_rt_data),
		.cmp_b(ex_src_a),
		.imm_value(ex_imm_value),
		.ex_pc(ex_pc),
		.is_branch(ex_is_branch),
		.branch_on_equal(ex_branch_on_equal),
		.result(ex_result),
		.branch_taken(branch_taken),
		.branch_target(branch_target)
	);
endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [5:0] {
		OP_LWI  = 6'b000010,
		OP_SWI  = 6'b001010,
		OP_ALU  = 6'b100000,
		OP_BEQ  = 6'b100110,
		OP_BNE  = 6'b100111,
		OP_ADDI = 6'b101000,
		OP_ORI  = 6'b101100
	} opcode_t;

	// sub_op field of the register form
	localparam logic [4:0] SUB_ADD = 5'b00000;
	localparam logic [4:0] SUB_SUB = 5'b00001;
	localparam logic [4:0] SUB_AND = 5'b00010;
	localparam logic [4:0] SUB_XOR = 5'b00011;
	localparam logic [4:0] SUB_OR  = 5'b00100;
	localparam logic [4:0] SUB_SLT = 5'b00111;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM
	} wb_sel_t;

	typedef union packed {
		struct packed {
			logic       spare;
			opcode_t    opcode;
			reg_addr_t  rt;
			reg_addr_t  ra;
			reg_addr_t  rb;
			logic [4:0] reserved;
			logic [4:0] sub_op;
		} r;
		struct packed {
			logic        spare;
			opcode_t     opcode;
			reg_addr_t   rt;
			reg_addr_t   ra;
			logic [14:0] imm15;
		} i;
	} instr_t;
endpackage

// ==== verilog/forward.sv ====
`timescale 1ns/1ps

module forward import cpu_pkg::*; (
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	input  reg_addr_t rt_addr,
	input  word_t     ra_data,
	input  word_t     rb_data,
	input  word_t     rt_data,
	input  logic      use_ra,
	input  logic      use_rb,
	input  logic      use_rt,
	input  reg_addr_t ex_dest_reg,
	input  logic      ex_reg_write,
	input  logic      ex_mem_read,
	input  word_t     ex_result,
	input  reg_addr_t mem_dest_reg,
	input  logic      mem_reg_write,
	input  word_t     mem_value,
	output word_t     fwd_ra,
	output word_t     fwd_rb,
	output word_t     fwd_rt,
	output logic      load_stall
);
	// newest producer wins, writeback is covered by the regfile bypass
	function automatic word_t pick(reg_addr_t addr, word_t file_data);
		word_t value;
		value = file_data;
		if (addr != '0) begin
			if (ex_reg_write && !ex_mem_read && addr == ex_dest_reg) begin
				value = ex_result;
			end else if (mem_reg_write && addr == mem_dest_reg) begin
				value = mem_value;
			end
		end
		return value;
	endfunction

	always_comb begin
		fwd_ra = pick(ra_addr, ra_data);
		fwd_rb = pick(rb_addr, rb_data);
		fwd_rt = pick(rt_addr, rt_data);
	end

	// load data only exists once the load reaches memory
	always_comb begin
		load_stall = 1'b0;
		if (ex_mem_read && ex_dest_reg != '0) begin
			load_stall = (use_ra && ra_addr == ex_dest_reg) ||
				(use_rb && rb_addr == ex_dest_reg) ||
				(use_rt && rt_addr == ex_dest_reg);
		end
	end
endmodule

// ==== verilog/pc.sv ====
`timescale 1ns/1ps

module pc import cpu_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  enable,
	input  logic  load_stall,
	input  logic  branch_taken,
	input  word_t branch_target,
	output word_t current_pc
);
	// a redirect overrides the stall
	always_ff @(posedge clock) begin
		if (reset) begin
			current_pc <= RESET_PC;
		end else if (enable) begin
			if (branch_taken) begin
				current_pc <= branch_target;
			end else if (!load_stall) begin
				current_pc <= current_pc + 32'd4;
			end
		end
	end

	// targets from execute must keep fetch on word boundaries
	assert property (@(posedge clock) disable iff (reset) current_pc[1:0] == 2'b00)
		else $error("fetch address lost word alignment");
endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      enable,
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	input  reg_addr_t rt_addr,
	output word_t     ra_data,
	output word_t     rb_data,
	output word_t     rt_data,
	input  logic      write_enable,
	input  reg_addr_t write_addr,
	input  word_t     write_data
);
	word_t regs [0:(1<<REG_ADDR_W)-1];

	// r0 reads zero, a pending write bypasses the array
	function automatic word_t read_port(reg_addr_t addr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (write_enable && addr == write_addr) begin
			value = write_data;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
		rt_data = read_port(rt_addr);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < (1<<REG_ADDR_W); i++) begin
				regs[i] <= '0;
			end
		end else if (enable && write_enable && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end
endmodule

// ==== verilog/regwalls.sv ====
`timescale 1ns/1ps

module regwalls import cpu_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      enable,
	input  logic      load_stall,
	input  logic      branch_taken,
	input  word_t     fetch_pc,
	input  word_t     im_data,
	input  alu_op_t   id_alu_op,
	input  logic      id_use_imm,
	input  word_t     id_imm_value,
	input  logic      id_reg_write,
	input  reg_addr_t id_dest_reg,
	input  logic      id_mem_read,
	input  logic      id_mem_write,
	input  logic      id_is_branch,
	input  logic      id_branch_on_equal,
	input  wb_sel_t   id_wb_sel,
	input  word_t     fwd_ra,
	input  word_t     fwd_rb,
	input  word_t     fwd_rt,
	input  word_t     ex_result,
	input  word_t     dm_rdata,
	output instr_t    id_instruction,
	output word_t     id_pc,
	output alu_op_t   ex_alu_op,
	output word_t     ex_src_a,
	output word_t     ex_src_b,
	output word_t     ex_rt_data,
	output word_t     ex_imm_value,
	output word_t     ex_pc,
	output logic      ex_is_branch,
	output logic      ex_branch_on_equal,
	output logic      ex_reg_write,
	output reg_addr_t ex_dest_reg,
	output logic      ex_mem_read,
	output logic      mem_reg_write,
	output reg_addr_t mem_dest_reg,
	output word_t     mem_value,
	output logic      dm_enable,
	output logic      dm_write,
	output word_t     dm_address,
	output word_t     dm_wdata,
	output logic      write_enable,
	output reg_addr_t write_addr,
	output word_t     write_data
);
	logic    ex_mem_write;
	wb_sel_t ex_wb_sel;
	logic    mem_is_load;
	logic    mem_is_store;
	wb_sel_t mem_wb_sel;
	word_t   mem_result;
	word_t   mem_rt_data;

	// fetch/decode, an all-zero word decodes as a no-op
	always_ff @(posedge clock) begin
		if (reset) begin
			id_instruction <= '0;
		end else if (enable) begin
			if (branch_taken) begin
				id_instruction <= '0;
			end else if (!load_stall) begin
				id_instruction <= im_data;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enable && !load_stall) begin
			id_pc <= fetch_pc;
		end
	end

	// decode/execute
	always_ff @(posedge clock) begin
		if (reset) begin
			ex_is_branch <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end else if (enable) begin
			if (branch_taken || load_stall) begin
				ex_is_branch <= 1'b0;
				ex_reg_write <= 1'b0;
				ex_mem_read <= 1'b0;
				ex_mem_write <= 1'b0;
			end else begin
				ex_is_branch <= id_is_branch;
				ex_reg_write <= id_reg_write;
				ex_mem_read <= id_mem_read;
				ex_mem_write <= id_mem_write;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enable) begin
			ex_alu_op <= id_alu_op;
			ex_branch_on_equal <= id_branch_on_equal;
			ex_dest_reg <= id_dest_reg;
			ex_wb_sel <= id_wb_sel;
			ex_src_a <= fwd_ra;
			ex_src_b <= id_use_imm ? id_imm_value : fwd_rb;
			ex_rt_data <= fwd_rt;
			ex_imm_value <= id_imm_value;
			ex_pc <= id_pc;
		end
	end

	// execute/memory
	always_ff @(posedge clock) begin
		if (reset) begin
			mem_reg_write <= 1'b0;
			mem_is_load <= 1'b0;
			mem_is_store <= 1'b0;
		end else if (enable) begin
			mem_reg_write <= ex_reg_write;
			mem_is_load <= ex_mem_read;
			mem_is_store <= ex_mem_write;
		end
	end

	always_ff @(posedge clock) begin
		if (enable) begin
			mem_dest_reg <= ex_dest_reg;
			mem_wb_sel <= ex_wb_sel;
			mem_result <= ex_result;
			mem_rt_data <= ex_rt_data;
		end
	end

	assign mem_value = (mem_wb_sel == WB_MEM) ? dm_rdata : mem_result;
	assign dm_enable = mem_is_load || mem_is_store;
	assign dm_write = mem_is_store;
	assign dm_address = mem_result;
	assign dm_wdata = mem_rt_data;

	// memory/writeback
	always_ff @(posedge clock) begin
		if (reset) begin
			write_enable <= 1'b0;
		end else if (enable) begin
			write_enable <= mem_reg_write;
		end
	end

	always_ff @(posedge clock) begin
		if (enable) begin
			write_addr <= mem_dest_reg;
			write_data <= mem_value;
		end
	end

	// decode never marks one instruction as both load and store
	assert property (@(posedge clock) disable iff (reset) !(mem_is_load && mem_is_store))
		else $error("memory stage holds both a load and a store");
endmodule
